/* Bender.yml */
package:
  name: cpuTop

export_include_dirs:
  - include

sources:
  - rtl/isaPkg.sv
  - rtl/busPkg.sv
  - rtl/alu.sv
  - rtl/regFile.sv
  - rtl/cpuCore.sv
  - rtl/busArbiter.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_asserts.sv
      - tests/cpuTop_tb.sv

/* cpuTop.f */
+incdir+include
rtl/isaPkg.sv
rtl/busPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/cpuCore.sv
rtl/busArbiter.sv
rtl/cpuTop.sv
tests/cpuTop_asserts.sv
tests/cpuTop_tb.sv

/* include/cpu_consts.svh */
// CPU word, register file and bus address sizes shared by the RTL and testbench
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and instruction width
`define WORD_W 16
// Register file size, R7 takes the JAL return address
`define NUM_REGS 8
`define LINK_REG 7
// Byte address, word accesses only
`define ADDR_W 16

`endif

/* rtl/alu.sv */
// Combinational ALU with add, subtract, xor and and-not, plus a zero flag
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu
    import isaPkg::*;
(
    input  logic [`WORD_W-1:0] inA,
    input  logic [`WORD_W-1:0] inB,
    input  aluOpT              op,
    output logic [`WORD_W-1:0] result,
    output logic               zero
);

    always_comb begin
        case (op)
            aluAdd:  result = inA + inB;
            // Second operand minus first, rt - rs or imm - rs
            aluSub:  result = inB - inA;
            aluXor:  result = inA ^ inB;
            aluAndn: result = inA & ~inB;
            default: result = '0;
        endcase
    end

    // Branch test in the core relies on this
    assign zero = (result == '0);

endmodule

/* rtl/busArbiter.sv */
// Round-robin arbiter joining the fetch and load/store masters onto one Wishbone bus
`timescale 1ns/1ns
`include "cpu_consts.svh"

module busArbiter
    import busPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               fetchCyc,
    input  logic               fetchStb,
    input  logic [`ADDR_W-1:0] fetchAdr,
    output logic [`WORD_W-1:0] fetchDatR,
    output logic               fetchAck,
    input  logic               dataCyc,
    input  logic               dataStb,
    input  logic               dataWe,
    input  logic [`ADDR_W-1:0] dataAdr,
    input  logic [`WORD_W-1:0] dataDatW,
    output logic [`WORD_W-1:0] dataDatR,
    output logic               dataAck,
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [`ADDR_W-1:0] adr,
    output logic [`WORD_W-1:0] datW,
    input  logic [`WORD_W-1:0] datR,
    input  logic               ack
);

    arbStateT state;
    masterT   lastServed, granted;
    logic     fetchReq, dataReq, busy;

    assign fetchReq = fetchCyc && fetchStb;
    assign dataReq  = dataCyc && dataStb;

    // Grant at cycle start, release one cycle after ack
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            // Fetch wins the first tie
            lastServed <= dataPort;
        end else begin
            case (state)
                idle: begin
                    if (fetchReq && dataReq) begin
                        state <= (lastServed == fetchPort) ? busyData : busyFetch;
                    end else if (fetchReq) begin
                        state <= busyFetch;
                    end else if (dataReq) begin
                        state <= busyData;
                    end
                end
                busyFetch, busyData: begin
                    if (ack) begin
                        state      <= idle;
                        lastServed <= granted;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign busy    = (state != idle);
    assign granted = (state == busyData) ? dataPort : fetchPort;

    // Bus mux, fetch never writes
    assign cyc  = busy && ((granted == dataPort) ? dataCyc : fetchCyc);
    assign stb  = busy && ((granted == dataPort) ? dataStb : fetchStb);
    assign we   = busy && (granted == dataPort) && dataWe;
    assign adr  = (granted == dataPort) ? dataAdr : fetchAdr;
    assign datW = dataDatW;

    // Read data shared, ack only to the granted master
    assign fetchDatR = datR;
    assign dataDatR  = datR;
    assign fetchAck  = ack && (state == busyFetch);
    assign dataAck   = ack && (state == busyData);

endmodule

/* rtl/busPkg.sv */
// Shared bus types: master index and arbiter state
package busPkg;

    // Masters that compete for the external bus
    typedef enum logic {fetchPort = 1'b0, dataPort = 1'b1} masterT;

    // Arbiter grant state, held for a whole bus cycle
    typedef enum logic [1:0] {
        idle      = 2'd0,
        busyFetch = 2'd1,
        busyData  = 2'd2
    } arbStateT;

endpackage

/* rtl/cpuCore.sv */
// Processor core: PC, one-word prefetch, decode, execute and two Wishbone masters
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuCore
    import isaPkg::*;
(
    input  logic               clk,
    input  logic               reset,
    output logic               fetchCyc,
    output logic               fetchStb,
    output logic [`ADDR_W-1:0] fetchAdr,
    input  logic [`WORD_W-1:0] fetchDatR,
    input  logic               fetchAck,
    output logic               dataCyc,
    output logic               dataStb,
    output logic               dataWe,
    output logic [`ADDR_W-1:0] dataAdr,
    output logic [`WORD_W-1:0] dataDatW,
    input  logic [`WORD_W-1:0] dataDatR,
    input  logic               dataAck,
    output logic               halted
);

    localparam int RegAddrW = $clog2(`NUM_REGS);
    // FSM states
    localparam logic [1:0] waitInstr = 2'd0;
    localparam logic [1:0] execute   = 2'd1;
    localparam logic [1:0] waitData  = 2'd2;
    // Write data sources
    localparam logic [1:0] srcAlu  = 2'd0;
    localparam logic [1:0] srcLoad = 2'd1;
    localparam logic [1:0] srcImm  = 2'd2;
    localparam logic [1:0] srcLink = 2'd3;

    logic [1:0]          state;
    logic [`ADDR_W-1:0]  pc, pcPlus2, target;
    instrT               ir, nextInstr;
    logic [`WORD_W-1:0]  slotWord;
    logic                slotValid, fetchDrop, fetchDone, dataDone;
    logic                accept, prefetch, refetch, taken;
    // Decode outputs
    aluOpT               aluOp;
    logic                useImm, signExt5, regWrite, isLoad, isStore, isJump;
    logic                isBeqz, isBnez, isHalt;
    logic [1:0]          wrSrc;
    logic [RegAddrW-1:0] wrAddr;
    // Datapath
    logic [`WORD_W-1:0]  imm5Ext, imm8Ext, disp11Ext, aluB, aluResult;
    logic [`WORD_W-1:0]  rdData1, rdData2, wrData;
    logic                aluZero, wrEn;

    regFile regs0 (
        .clk(clk), .reset(reset),
        .rdAddr1(ir.rForm.rs), .rdAddr2(ir.rForm.rt),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdData1(rdData1), .rdData2(rdData2)
    );

    alu alu0 (.inA(rdData1), .inB(aluB), .op(aluOp), .result(aluResult), .zero(aluZero));

    always_comb begin
        aluOp    = aluAdd;
        useImm   = 1'b1;
        signExt5 = 1'b1;
        regWrite = 1'b0;
        wrSrc    = srcAlu;
        wrAddr   = ir.i1Form.rd;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isJump   = 1'b0;
        isBeqz   = 1'b0;
        isBnez   = 1'b0;
        isHalt   = 1'b0;
        case (ir.rForm.opcode)
            opAlu: begin
                aluOp    = aluOpT'(ir.rForm.func);
                useImm   = 1'b0;
                regWrite = 1'b1;
                wrAddr   = ir.rForm.rd;
            end
            opAddi: regWrite = 1'b1;
            opSubi: begin
                aluOp    = aluSub;
                regWrite = 1'b1;
            end
            // Logic immediates are zero-extended
            opXori: begin
                aluOp    = aluXor;
                signExt5 = 1'b0;
                regWrite = 1'b1;
            end
            opAndni: begin
                aluOp    = aluAndn;
                signExt5 = 1'b0;
                regWrite = 1'b1;
            end
            // LBI targets the rs slot
            opLbi: begin
                regWrite = 1'b1;
                wrSrc    = srcImm;
                wrAddr   = ir.i2Form.rs;
            end
            opLd: begin
                isLoad   = 1'b1;
                regWrite = 1'b1;
                wrSrc    = srcLoad;
            end
            opSt:   isStore = 1'b1;
            opBeqz: isBeqz = 1'b1;
            opBnez: isBnez = 1'b1;
            opJ:    isJump = 1'b1;
            opJal: begin
                isJump   = 1'b1;
                regWrite = 1'b1;
                wrSrc    = srcLink;
                wrAddr   = RegAddrW'(`LINK_REG);
            end
            opHalt: isHalt = 1'b1;
            opNop:  ;
            default: ;
        endcase
    end

    // Immediate extension
    assign imm5Ext   = signExt5 ? {{(`WORD_W-5){ir.i1Form.imm5[4]}}, ir.i1Form.imm5}
                                : {{(`WORD_W-5){1'b0}}, ir.i1Form.imm5};
    assign imm8Ext   = {{(`WORD_W-8){ir.i2Form.imm8[7]}}, ir.i2Form.imm8};
    assign disp11Ext = {{(`WORD_W-11){ir.jForm.disp11[10]}}, ir.jForm.disp11};

    // Branches pass rs through the ALU unchanged so zero tests it
    assign aluB = !useImm ? rdData2 : ((isBeqz || isBnez) ? '0 : imm5Ext);

    // Targets relative to the next instruction
    assign pcPlus2 = pc + `ADDR_W'(2);
    assign target  = pcPlus2 + (isJump ? disp11Ext : imm8Ext);
    assign taken   = (state == execute) && (isJump || (isBeqz && aluZero) || (isBnez && !aluZero));

    always_comb begin
        case (wrSrc)
            srcLoad: wrData = dataDatR;
            srcImm:  wrData = imm8Ext;
            srcLink: wrData = pcPlus2;
            default: wrData = aluResult;
        endcase
    end

    // Loads write on their ack, everything else in execute
    assign wrEn = ((state == execute) && regWrite && !isLoad) ||
                  ((state == waitData) && dataDone && isLoad);

    // Fetch handshake and prefetch slot
    assign fetchDone = fetchCyc && fetchAck;
    assign dataDone  = dataCyc && dataAck;
    assign nextInstr = slotValid ? slotWord : fetchDatR;
    // Outstanding fetch in waitInstr is always for pc unless marked dropped
    assign accept    = (state == waitInstr) && !halted && (slotValid || (fetchDone && !fetchDrop));
    // No prefetch behind HALT
    assign prefetch  = accept && (nextInstr.jForm.opcode != opHalt);
    assign refetch   = (state == waitInstr) && !slotValid && !fetchCyc && !halted;
    assign fetchStb  = fetchCyc;
    assign dataStb   = dataCyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchCyc  <= 1'b0;
            fetchDrop <= 1'b0;
            slotValid <= 1'b0;
        end else begin
            if (prefetch || refetch) begin
                fetchCyc <= 1'b1;
            end else if (fetchDone) begin
                fetchCyc <= 1'b0;
            end
            // A taken branch leaves an in-flight fetch stale
            if (fetchDone) begin
                fetchDrop <= 1'b0;
            end else if (taken && fetchCyc) begin
                fetchDrop <= 1'b1;
            end
            if (accept || taken) begin
                slotValid <= 1'b0;
            end else if (fetchDone && !fetchDrop) begin
                slotValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= waitInstr;
            pc      <= '0;
            halted  <= 1'b0;
            dataCyc <= 1'b0;
        end else begin
            case (state)
                waitInstr: if (accept) state <= execute;
                execute: begin
                    state <= (isLoad || isStore) ? waitData : waitInstr;
                    if (isHalt) begin
                        halted <= 1'b1;
                    end else if (isLoad || isStore) begin
                        dataCyc <= 1'b1;
                    end else begin
                        pc <= taken ? target : pcPlus2;
                    end
                end
                waitData: begin
                    if (dataDone) begin
                        dataCyc <= 1'b0;
                        pc      <= pcPlus2;
                        state   <= waitInstr;
                    end
                end
                default: state <= waitInstr;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept) ir <= nextInstr;
        if (fetchDone) slotWord <= fetchDatR;
        if (prefetch) begin
            fetchAdr <= pcPlus2;
        end else if (refetch) begin
            fetchAdr <= pc;
        end
        if ((state == execute) && (isLoad || isStore)) begin
            dataWe   <= isStore;
            dataAdr  <= aluResult;
            // Store data from the I1 rd slot, same bits as rt
            dataDatW <= rdData2;
        end
    end

endmodule

/* rtl/cpuTop.sv */
// CPU top level: core with its fetch and load/store masters behind the bus arbiter
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuTop (
    input  logic               clk,
    input  logic               reset,
    input  logic [`WORD_W-1:0] datR,
    input  logic               ack,
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [`ADDR_W-1:0] adr,
    output logic [`WORD_W-1:0] datW,
    output logic               halted
);

    // Instruction fetch master
    logic               fetchCyc, fetchStb, fetchAck;
    logic [`ADDR_W-1:0] fetchAdr;
    logic [`WORD_W-1:0] fetchDatR;
    // Load/store master
    logic               dataCyc, dataStb, dataWe, dataAck;
    logic [`ADDR_W-1:0] dataAdr;
    logic [`WORD_W-1:0] dataDatW, dataDatR;

    cpuCore core0 (
        .clk(clk), .reset(reset),
        .fetchCyc(fetchCyc), .fetchStb(fetchStb), .fetchAdr(fetchAdr),
        .fetchDatR(fetchDatR), .fetchAck(fetchAck),
        .dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe), .dataAdr(dataAdr),
        .dataDatW(dataDatW), .dataDatR(dataDatR), .dataAck(dataAck),
        .halted(halted)
    );

    // Single external bus, memory lives outside
    busArbiter arb0 (
        .clk(clk), .reset(reset),
        .fetchCyc(fetchCyc), .fetchStb(fetchStb), .fetchAdr(fetchAdr),
        .fetchDatR(fetchDatR), .fetchAck(fetchAck),
        .dataCyc(dataCyc), .dataStb(dataStb), .dataWe(dataWe), .dataAdr(dataAdr),
        .dataDatW(dataDatW), .dataDatR(dataDatR), .dataAck(dataAck),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .datR(datR), .ack(ack)
    );

endmodule

/* rtl/isaPkg.sv */
// ISA types: opcodes, ALU operations and the instruction word layouts
package isaPkg;

    // Major opcodes, instruction bits 15:11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opLbi   = 5'b11000,
        // Register ALU ops, function in bits 1:0
        opAlu   = 5'b11011
    } opcodeT;

    // Same encoding as the R-format function field
    typedef enum logic [1:0] {
        aluAdd  = 2'b00,
        aluSub  = 2'b01,
        aluXor  = 2'b10,
        aluAndn = 2'b11
    } aluOpT;

    // One instruction word seen through each format
    typedef union packed {
        struct packed {opcodeT opcode; logic [2:0] rs; logic [2:0] rt;
                       logic [2:0] rd; logic [1:0] func;} rForm;
        struct packed {opcodeT opcode; logic [2:0] rs; logic [2:0] rd;
                       logic [4:0] imm5;} i1Form;
        struct packed {opcodeT opcode; logic [2:0] rs; logic [7:0] imm8;} i2Form;
        struct packed {opcodeT opcode; logic [10:0] disp11;} jForm;
    } instrT;

endpackage

/* rtl/regFile.sv */
// Eight-entry register file with two asynchronous reads and one synchronous write
`timescale 1ns/1ns
`include "cpu_consts.svh"

module regFile (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [$clog2(`NUM_REGS)-1:0] rdAddr1,
    input  logic [$clog2(`NUM_REGS)-1:0] rdAddr2,
    input  logic                         wrEn,
    input  logic [$clog2(`NUM_REGS)-1:0] wrAddr,
    input  logic [`WORD_W-1:0]           wrData,
    output logic [`WORD_W-1:0]           rdData1,
    output logic [`WORD_W-1:0]           rdData2
);

    logic [`WORD_W-1:0] regs [`NUM_REGS];

    // R0 is writable like any other register
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

endmodule

/* tests/cpuTop_asserts.sv */
// Wishbone protocol checks on the shared bus, bound into the arbiter
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuTop_asserts
    import busPkg::*;
(
    input logic               clk,
    input logic               reset,
    input arbStateT           state,
    input logic               cyc,
    input logic               stb,
    input logic               ack,
    input logic [`ADDR_W-1:0] adr,
    input logic               fetchAck,
    input logic               dataAck
);

    int failCount = 0;

    // Strobe only inside a cycle
    stbInCyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc) else begin
        failCount++;
        $error("stb asserted without cyc");
    end

    // First reset edge skipped since state is unknown before it
    quietInReset: assert property (@(posedge clk) (reset && $past(reset)) |-> !cyc) else begin
        failCount++;
        $error("cyc high during reset");
    end

    // Granted master holds its address
    adrStable: assert property (@(posedge clk) disable iff (reset)
                                (state != idle && !ack) |=> $stable(adr)) else begin
        failCount++;
        $error("adr changed before ack");
    end

    oneAck: assert property (@(posedge clk) disable iff (reset) !(fetchAck && dataAck)) else begin
        failCount++;
        $error("ack routed to both masters");
    end

endmodule

bind busArbiter cpuTop_asserts asserts0 (
    .clk(clk), .reset(reset), .state(state), .cyc(cyc), .stb(stb), .ack(ack),
    .adr(adr), .fetchAck(fetchAck), .dataAck(dataAck)
);

/* tests/cpuTop_tb.sv */
// CPU testbench with Wishbone memory model, program loader, reference ISA model and store checker
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuTop_tb
    import isaPkg::*;
();

    logic               clk, reset, ack, cyc, stb, we, halted;
    logic [`WORD_W-1:0] datR, datW;
    logic [`ADDR_W-1:0] adr;
    // Memory under test and the reference copy
    logic [`WORD_W-1:0] mem [256];
    logic [`WORD_W-1:0] refMem [256];
    // Expected stores from the model and acked stores from the bus
    logic [`ADDR_W-1:0] expAdrQ [$];
    logic [`WORD_W-1:0] expDatQ [$];
    logic [`ADDR_W-1:0] gotAdrQ [$];
    logic [`WORD_W-1:0] gotDatQ [$];
    logic [`WORD_W-1:0] prog [$];
    integer             seed;
    int                 waitCnt, cycles, limit;
    logic               pending;

    cpuTop dut0 (
        .clk(clk), .reset(reset), .datR(datR), .ack(ack),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW), .halted(halted)
    );

    always #4 clk = ~clk;

    task automatic failRun(input string msg);
        $display("Error: %s", msg);
        $display("Test FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic checkValue(input string name, input logic [`WORD_W-1:0] got,
                              input logic [`WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
            $display("Test FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // One instruction encoder per format
    function automatic logic [`WORD_W-1:0] regOp(input int func, input int rs, input int rt,
                                                 input int rd);
        return {opAlu, 3'(rs), 3'(rt), 3'(rd), 2'(func)};
    endfunction

    function automatic logic [`WORD_W-1:0] shortImm(input opcodeT op, input int rs,
                                                    input int rd, input int imm);
        return {op, 3'(rs), 3'(rd), 5'(imm)};
    endfunction

    function automatic logic [`WORD_W-1:0] longImm(input opcodeT op, input int rs, input int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic [`WORD_W-1:0] jumpTo(input opcodeT op, input int disp);
        return {op, 11'(disp)};
    endfunction

    // 0 add, 1 b minus a, 2 xor, 3 a and not b
    function automatic logic [`WORD_W-1:0] applyAluOp(input logic [1:0] func,
                                                      input logic [`WORD_W-1:0] a,
                                                      input logic [`WORD_W-1:0] b);
        case (func)
            2'd0:    return a + b;
            2'd1:    return b - a;
            2'd2:    return a ^ b;
            default: return a & ~b;
        endcase
    endfunction

    // ISA model on refMem that fills the store queues and returns the executed count
    function automatic int modelProgram();
        logic [`WORD_W-1:0] r [`NUM_REGS];
        logic [`ADDR_W-1:0] pc, nextPc, addr;
        logic [`WORD_W-1:0] sImm5, zImm5, sImm8, sDisp;
        instrT              ins;
        int                 count;
        for (int i = 0; i < `NUM_REGS; i++) begin
            r[i] = '0;
        end
        pc = '0;
        count = 0;
        expAdrQ.delete();
        expDatQ.delete();
        while (count < 1000) begin
            ins = refMem[pc[8:1]];
            count++;
            nextPc = pc + 16'd2;
            sImm5 = {{(`WORD_W-5){ins.i1Form.imm5[4]}}, ins.i1Form.imm5};
            zImm5 = {{(`WORD_W-5){1'b0}}, ins.i1Form.imm5};
            sImm8 = {{(`WORD_W-8){ins.i2Form.imm8[7]}}, ins.i2Form.imm8};
            sDisp = {{(`WORD_W-11){ins.jForm.disp11[10]}}, ins.jForm.disp11};
            addr = r[ins.i1Form.rs] + sImm5;
            case (ins.jForm.opcode)
                opHalt:  return count;
                opAlu:   r[ins.rForm.rd] = applyAluOp(ins.rForm.func, r[ins.rForm.rs],
                                                      r[ins.rForm.rt]);
                opAddi:  r[ins.i1Form.rd] = r[ins.i1Form.rs] + sImm5;
                opSubi:  r[ins.i1Form.rd] = sImm5 - r[ins.i1Form.rs];
                opXori:  r[ins.i1Form.rd] = r[ins.i1Form.rs] ^ zImm5;
                opAndni: r[ins.i1Form.rd] = r[ins.i1Form.rs] & ~zImm5;
                opLbi:   r[ins.i2Form.rs] = sImm8;
                opLd:    r[ins.i1Form.rd] = refMem[addr[8:1]];
                opSt: begin
                    refMem[addr[8:1]] = r[ins.i1Form.rd];
                    expAdrQ.push_back(addr);
                    expDatQ.push_back(r[ins.i1Form.rd]);
                end
                opBeqz:  if (r[ins.i2Form.rs] == '0) nextPc = nextPc + sImm8;
                opBnez:  if (r[ins.i2Form.rs] != '0) nextPc = nextPc + sImm8;
                opJ:     nextPc = nextPc + sDisp;
                opJal: begin
                    r[`LINK_REG] = nextPc;
                    nextPc = nextPc + sDisp;
                end
                default: ;
            endcase
            pc = nextPc;
        end
        return count;
    endfunction

    // Wishbone slave with 0 to 3 random wait cycles
    always @(negedge clk) begin
        if (ack) begin
            ack = 1'b0;
            pending = 1'b0;
        end else if (cyc && stb) begin
            if (!pending) begin
                pending = 1'b1;
                waitCnt = $random(seed) & 3;
            end
            if (waitCnt == 0) begin
                ack = 1'b1;
                if (we) begin
                    mem[adr[8:1]] = datW;
                    gotAdrQ.push_back(adr);
                    gotDatQ.push_back(datW);
                end else begin
                    datR = mem[adr[8:1]];
                end
            end else begin
                waitCnt--;
            end
        end
    end

    // Acked writes against the expected store order
    always @(posedge clk) begin
        if (gotAdrQ.size() != 0) begin
            if (expAdrQ.size() == 0) begin
                failRun("a store reached the bus that the reference never makes");
            end else begin
                checkValue("adr", gotAdrQ.pop_front(), expAdrQ.pop_front());
                checkValue("datW", gotDatQ.pop_front(), expDatQ.pop_front());
            end
        end
    end

    // Any bus assertion failure ends the run
    always @(negedge clk) begin
        if (dut0.arb0.asserts0.failCount != 0) begin
            failRun("a bus protocol assertion failed");
        end
    end

    // Pattern over the whole word index
    task automatic fillMemory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i)};
        end
    endtask

    task automatic writeDirectedProgram();
        prog.delete();
        // R6 holds base 0xff80 so data words are 184 to 199
        prog.push_back(longImm(opLbi, 6, 8'h80));
        prog.push_back(longImm(opLbi, 1, 8'h05));
        prog.push_back(longImm(opLbi, 2, 8'hfd));
        // Register forms with R0 as a destination
        prog.push_back(regOp(0, 1, 2, 3));
        prog.push_back(regOp(1, 1, 2, 4));
        prog.push_back(regOp(2, 1, 2, 5));
        prog.push_back(regOp(3, 2, 1, 0));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(shortImm(opSt, 6, (i + 3) % 6, 2 * i));
        end
        // Negative imm5 for ADDI and SUBI and high bit set for XORI and ANDNI
        prog.push_back(shortImm(opAddi, 1, 3, 5'h1f));
        prog.push_back(shortImm(opSubi, 1, 4, 5'h10));
        prog.push_back(shortImm(opXori, 2, 5, 5'h1f));
        prog.push_back(shortImm(opAndni, 2, 0, 5'h11));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(shortImm(opSt, 6, (i + 3) % 6, 8 + 2 * i));
        end
        // Load a preloaded word and one stored above
        prog.push_back(shortImm(opLd, 6, 1, -16));
        prog.push_back(shortImm(opLd, 6, 2, 2));
        prog.push_back(regOp(0, 1, 2, 3));
        prog.push_back(shortImm(opSt, 6, 3, -2));
        // Skipped stores would show up as extra bus writes
        prog.push_back(longImm(opLbi, 1, 0));
        prog.push_back(longImm(opBeqz, 1, 2));
        prog.push_back(shortImm(opSt, 6, 1, -4));
        prog.push_back(longImm(opBnez, 1, 2));
        prog.push_back(longImm(opLbi, 2, 8'h77));
        prog.push_back(longImm(opBnez, 2, 4));
        prog.push_back(shortImm(opSt, 6, 2, -4));
        prog.push_back(shortImm(opSt, 6, 2, -6));
        prog.push_back(longImm(opBeqz, 2, 2));
        prog.push_back(shortImm(opSt, 6, 2, -4));
        prog.push_back(jumpTo(opJ, 2));
        prog.push_back(shortImm(opSt, 6, 6, -6));
        prog.push_back(jumpTo(opJal, 2));
        prog.push_back(shortImm(opSt, 6, 6, -6));
        // Link address out of R7
        prog.push_back(shortImm(opSt, 6, 7, -6));
        prog.push_back(jumpTo(opHalt, 0));
        mem[184] = 16'h1234;
    endtask

    task automatic makeRandomProgram();
        opcodeT immOps [4];
        int     len, kind, skip;
        immOps = '{opAddi, opSubi, opXori, opAndni};
        len = 28 + randBelow(12);
        prog.delete();
        prog.push_back(longImm(opLbi, 6, 8'h80));
        for (int i = 0; i < 6; i++) begin
            prog.push_back(longImm(opLbi, i, randBelow(256)));
        end
        // R6 stays the data base, so destinations are R0 to R5
        while (prog.size() < len - 1) begin
            kind = randBelow(9);
            skip = randBelow(3);
            // Forward targets land on or before the final HALT
            if (prog.size() + 1 + skip > len - 1) skip = 0;
            case (kind)
                0, 1: prog.push_back(regOp(randBelow(4), randBelow(8), randBelow(8), randBelow(6)));
                2: prog.push_back(shortImm(immOps[randBelow(4)], randBelow(8), randBelow(6),
                                           randBelow(32)));
                3: prog.push_back(longImm(opLbi, randBelow(6), randBelow(256)));
                4: prog.push_back(shortImm(opLd, 6, randBelow(6), 2 * randBelow(16) - 16));
                5: prog.push_back(shortImm(opSt, 6, randBelow(8), 2 * randBelow(16) - 16));
                6: prog.push_back(longImm(randBelow(2) ? opBnez : opBeqz, randBelow(8), 2 * skip));
                7: prog.push_back(jumpTo(randBelow(2) ? opJal : opJ, 2 * skip));
                default: prog.push_back(jumpTo(opNop, 0));
            endcase
        end
        prog.push_back(jumpTo(opHalt, 0));
        for (int i = 184; i < 200; i++) begin
            mem[i] = 16'($random(seed));
        end
    endtask

    task automatic executeOnDut();
        int count;
        for (int i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
        refMem = mem;
        count = modelProgram();
        // 60 cycles per executed instruction
        limit = 60 * count;
        reset = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkValue("cyc", 16'(cyc), 16'd0);
        end
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            failRun("the processor did not halt before the cycle limit");
        end else begin
            // Halted holds and the bus stays quiet
            repeat (4) begin
                @(negedge clk);
                checkValue("cyc", 16'(cyc), 16'd0);
                checkValue("halted", 16'(halted), 16'd1);
            end
            if (expAdrQ.size() != 0) begin
                failRun("the processor halted before making all expected stores");
            end else begin
                for (int i = 0; i < 256; i++) begin
                    checkValue($sformatf("mem[%0d]", i), mem[i], refMem[i]);
                end
            end
        end
    endtask

    initial begin
        seed = 32'hdb88;
        clk = 1'b0;
        reset = 1'b1;
        ack = 1'b0;
        datR = '0;
        pending = 1'b0;
        waitCnt = 0;
        fillMemory();
        writeDirectedProgram();
        executeOnDut();
        for (int p = 0; p < 3; p++) begin
            fillMemory();
            makeRandomProgram();
            executeOnDut();
        end
        $display("Test OK");
        $finish;
    end

endmodule
